/* verilog.f */
src/smpc_pkg.sv
src/smpc_oreg_ram.sv
src/smpc_rtc.sv
src/smpc_host_regs.sv
src/smpc_cmd_seq.sv
src/smpc.sv
tb/smpc_clkgen.sv
tb/smpc_asserts.sv
tb/smpc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := smpc_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* tb/smpc_tb.sv */
`timescale 1ns/1ps

module smpc_tb;

	localparam logic [31:0] TICKS = 32'd50;
	localparam int N_RANDOM = 8;
	localparam int N_CMDS = N_RANDOM + 10;
	localparam int LIMIT = 40 * (N_CMDS * (smpc_pkg::WAIT_CMD + smpc_pkg::WAIT_INTBACK) +
		4 * TICKS);

	logic                   CLK;
	logic                   RST_N;
	logic                   ce;
	logic                   mres_n;
	logic                   time_set_in;
	logic [3:0]             ac;
	logic [6:1]             a;
	logic [7:0]             di;
	logic [7:0]             dout;
	logic                   cs_n;
	logic                   rw_n;
	logic                   mirq_n;
	smpc_pkg::reset_lines_t resets;
	smpc_pkg::reset_lines_t exp_lines;
	logic                   exp_ste;
	logic                   exp_resd;
	logic [31:0]            rng;
	int                     cycle_cnt = 0;
	int                     nmi_low_cnt = 0;
	int                     mirq_low_cnt = 0;
	string                  cmp_name;
	logic [31:0]            cmp_got;
	logic [31:0]            cmp_exp;
	int                     cmp_seq = 0;
	int                     cmp_done = 0;

	smpc_clkgen #(.PERIOD_NS(10), .RESET_CYCLES(2)) u_clkgen (.CLK(CLK), .RST_N(RST_N));

	smpc #(.TICKS_PER_SEC(TICKS)) u_smpc (
		.CLK(CLK), .RST_N(RST_N), .ce(ce), .mres_n(mres_n), .time_set_in(time_set_in),
		.ac(ac), .a(a), .di(di), .dout(dout), .cs_n(cs_n), .rw_n(rw_n),
		.resets(resets), .mirq_n(mirq_n)
	);

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) begin
			$display("TEST FAILED");
			$fatal(1, "Timeout: the test did not finish within %0d cycles", LIMIT);
		end
	end

	always @(posedge CLK) begin
		if (RST_N && !resets.mshnmi_n) nmi_low_cnt <= nmi_low_cnt + 1;
		if (!mirq_n) mirq_low_cnt <= mirq_low_cnt + 1;
	end

	always @(posedge CLK) begin
		if (cmp_seq != cmp_done) begin
			check(cmp_name, cmp_got, cmp_exp);
			cmp_done <= cmp_seq;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		cmp_name = name;
		cmp_got = got;
		cmp_exp = exp;
		cmp_seq = cmp_seq + 1;
		while (cmp_done != cmp_seq) @(posedge CLK);
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] power_cmd(input logic [2:0] n);
		case (n)
			3'd0: return smpc_pkg::CMD_MSHON;
			3'd1: return smpc_pkg::CMD_SSHON;
			3'd2: return smpc_pkg::CMD_SSHOFF;
			3'd3: return smpc_pkg::CMD_SNDON;
			3'd4: return smpc_pkg::CMD_SNDOFF;
			3'd5: return smpc_pkg::CMD_CDON;
			default: return smpc_pkg::CMD_CDOFF;
		endcase
	endfunction

	function automatic smpc_pkg::reset_lines_t expected_lines(input smpc_pkg::reset_lines_t lines,
		input logic [7:0] cmd);
		smpc_pkg::reset_lines_t r;
		r = lines;
		case (cmd)
			smpc_pkg::CMD_MSHON: {r.mshres_n, r.mshnmi_n} = 2'b11;
			smpc_pkg::CMD_SSHON: {r.sshres_n, r.sshnmi_n} = 2'b11;
			smpc_pkg::CMD_SSHOFF: {r.sshres_n, r.sshnmi_n} = 2'b01;
			smpc_pkg::CMD_SNDON: r.sndres_n = 1'b1;
			smpc_pkg::CMD_SNDOFF: r.sndres_n = 1'b0;
			smpc_pkg::CMD_CDON: r.cdres_n = 1'b1;
			smpc_pkg::CMD_CDOFF: r.cdres_n = 1'b0;
			smpc_pkg::CMD_NMIREQ: r.mshnmi_n = 1'b1;	// Released again in END
			default: ;
		endcase
		return r;
	endfunction

	function automatic int bcd_to_int(input logic [7:0] b);
		return int'(b[7:4]) * 10 + int'(b[3:0]);
	endfunction

	function automatic logic [7:0] int_to_bcd(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	function automatic int month_days(input int m);
		if (m == 2) return 28;	// No leap years
		if (m == 4 || m == 6 || m == 9 || m == 11) return 30;
		return 31;
	endfunction

	function automatic smpc_pkg::rtc_time_t rtc_advance(input smpc_pkg::rtc_time_t t,
		input int secs);
		smpc_pkg::rtc_time_t r;
		int s;
		int mi;
		int h;
		int d;
		int mo;
		int y;
		int n;
		s = bcd_to_int(t.sec);
		mi = bcd_to_int(t.min);
		h = bcd_to_int(t.hour);
		d = bcd_to_int(t.days);
		mo = int'(t.month);
		y = bcd_to_int(t.year[15:8]) * 100 + bcd_to_int(t.year[7:0]);
		for (n = 0; n < secs; n++) begin
			s = s + 1;
			if (s == 60) begin
				s = 0;
				mi = mi + 1;
			end
			if (mi == 60) begin
				mi = 0;
				h = h + 1;
			end
			if (h == 24) begin
				h = 0;
				d = d + 1;
			end
			if (d > month_days(mo)) begin
				d = 1;
				mo = mo + 1;
			end
			if (mo == 13) begin
				mo = 1;
				y = y + 1;
			end
		end
		r = t;	// Day of week is not advanced
		r.sec = int_to_bcd(s);
		r.min = int_to_bcd(mi);
		r.hour = int_to_bcd(h);
		r.days = int_to_bcd(d);
		r.month = 4'(mo);
		r.year = {int_to_bcd(y / 100), int_to_bcd(y % 100)};
		return r;
	endfunction

	function automatic logic [7:0] time_byte(input smpc_pkg::rtc_time_t t, input int idx);
		case (idx)
			1: return t.year[15:8];
			2: return t.year[7:0];
			3: return {t.day, t.month};
			4: return t.days;
			5: return t.hour;
			6: return t.min;
			default: return t.sec;
		endcase
	endfunction

	// A second may tick while OREG1..7 are written, so bytes before j may lag by one
	function automatic logic time_matches(input logic [7:1][7:0] got,
		input smpc_pkg::rtc_time_t set, input int kmin, input int kmax);
		smpc_pkg::rtc_time_t lo;
		smpc_pkg::rtc_time_t hi;
		int k;
		int j;
		int i;
		logic ok;
		for (k = kmin; k <= kmax; k++) begin
			lo = rtc_advance(set, k);
			hi = rtc_advance(set, k + 1);
			for (j = 1; j <= 8; j++) begin
				ok = 1'b1;
				for (i = 1; i <= 7; i++)
					if (got[3'(i)] != time_byte(i < j ? lo : hi, i)) ok = 1'b0;
				if (ok) return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic bus_write(input logic [6:0] addr, input logic [7:0] data);
		@(posedge CLK);
		a <= addr[6:1];
		di <= data;
		cs_n <= 1'b0;
		rw_n <= 1'b0;
		@(posedge CLK);
		cs_n <= 1'b1;
		rw_n <= 1'b1;
	endtask

	task automatic bus_read(input logic [6:0] addr, output logic [7:0] data);
		@(posedge CLK);
		a <= addr[6:1];
		cs_n <= 1'b0;
		rw_n <= 1'b1;
		@(posedge CLK);	// DUT latches dout here
		cs_n <= 1'b1;
		@(posedge CLK);
		data = dout;
	endtask

	task automatic read_oreg(input logic [4:0] idx, output logic [7:0] data);
		bus_read(7'h21 + {1'b0, idx, 1'b0}, data);
	endtask

	task automatic write_iregs(input logic [6:0][7:0] v);
		int i;
		for (i = 0; i < 7; i++)
			bus_write(smpc_pkg::ADDR_IREG0 + 7'(2 * i), v[3'(i)]);
	endtask

	task automatic run_command(input logic [7:0] cmd);
		logic [7:0] sf;
		bus_write(smpc_pkg::ADDR_COMREG, cmd);
		bus_write(smpc_pkg::ADDR_SF, 8'h01);
		sf = 8'h01;
		while (sf[0]) bus_read(smpc_pkg::ADDR_SF, sf);	// Poll until the command ends
	endtask

	task automatic run_intback();
		int m0;
		logic [7:0] v;
		write_iregs({8'h00, 8'h00, 8'h00, 8'h00, 8'hF0, 8'h00, 8'h01});
		m0 = mirq_low_cnt;
		run_command(smpc_pkg::CMD_INTBACK);
		expect_value("mirq_n low during INTBACK", 32'(mirq_low_cnt > m0), 32'd1);
		bus_read(smpc_pkg::ADDR_SR, v);
		expect_value("sr", 32'(v), 32'h4F);
		read_oreg(5'd0, v);
		expect_value("oreg0", 32'(v), 32'({exp_ste, exp_resd, 6'b000000}));
		read_oreg(5'd9, v);
		expect_value("oreg9", 32'(v), 32'({4'b0000, ac}));
		read_oreg(5'd10, v);
		expect_value("oreg10", 32'(v), 32'({4'b0011, ~exp_lines.mshnmi_n, 1'b0,
			~exp_lines.sysres_n, ~exp_lines.sndres_n}));
		read_oreg(5'd11, v);
		expect_value("oreg11", 32'(v), 32'({1'b0, ~exp_lines.cdres_n, 6'b000000}));
		read_oreg(5'd31, v);
		expect_value("oreg31", 32'(v), 32'(smpc_pkg::CMD_INTBACK));
	endtask

	task automatic settime_check(input smpc_pkg::rtc_time_t set);
		logic [7:1][7:0] got;
		logic [7:0] b;
		int t0;
		int kmin;
		int kmax;
		int i;
		write_iregs({set.sec, set.min, set.hour, set.days, {set.day, set.month},
			set.year[7:0], set.year[15:8]});
		t0 = cycle_cnt;
		run_command(smpc_pkg::CMD_SETTIME);
		exp_ste = 1'b1;
		run_intback();
		kmin = int'(smpc_pkg::WAIT_INTBACK) / int'(TICKS);	// INTBACK alone waits this long
		kmax = (cycle_cnt - t0) / int'(TICKS);
		for (i = 1; i <= 7; i++) begin
			read_oreg(5'(i), b);
			got[3'(i)] = b;
		end
		expect_value("oreg1..7 against rtc reference",
			32'(time_matches(got, set, kmin, kmax)), 32'd1);
	endtask

	initial begin
		smpc_pkg::rtc_time_t set_time;
		logic [7:0] cmd;
		logic [7:0] v;
		logic [7:0] sr_before;
		int n0;
		int i;
		ce = 1'b0;
		mres_n = 1'b1;
		time_set_in = 1'b0;
		ac = 4'h0;
		a = '0;
		di = '0;
		cs_n = 1'b1;
		rw_n = 1'b1;
		rng = 32'h80dec777;
		@(posedge CLK);
		while (RST_N !== 1'b1) @(posedge CLK);
		rng = xorshift(rng);
		ce <= 1'b1;
		ac <= rng[3:0];
		@(posedge CLK);
		expect_value("resets", 32'(resets), 32'h00);
		expect_value("mirq_n", 32'(mirq_n), 32'd1);
		bus_read(smpc_pkg::ADDR_SF, v);
		expect_value("sf", 32'(v), 32'h00);

		mres_n <= 1'b0;
		repeat (3) @(posedge CLK);
		mres_n <= 1'b1;
		@(posedge CLK);
		exp_lines = '{mshres_n: 1'b1, mshnmi_n: 1'b1, sshres_n: 1'b0, sshnmi_n: 1'b1,
			sysres_n: 1'b1, sndres_n: 1'b0, cdres_n: 1'b1};
		exp_ste = 1'b0;
		exp_resd = 1'b1;
		expect_value("resets", 32'(resets), 32'(exp_lines));
		expect_value("mirq_n", 32'(mirq_n), 32'd1);
		bus_read(smpc_pkg::ADDR_SF, v);
		expect_value("sf", 32'(v), 32'h00);

		for (i = 0; i < N_RANDOM; i++) begin
			rng = xorshift(rng);
			cmd = power_cmd(3'(rng % 32'd7));
			run_command(cmd);
			exp_lines = expected_lines(exp_lines, cmd);
			expect_value("resets", 32'(resets), 32'(exp_lines));
			read_oreg(5'd31, v);
			expect_value("oreg31", 32'(v), 32'(cmd));
		end

		n0 = nmi_low_cnt;
		run_command(smpc_pkg::CMD_NMIREQ);
		exp_lines = expected_lines(exp_lines, smpc_pkg::CMD_NMIREQ);
		expect_value("mshnmi_n low during NMIREQ", 32'(nmi_low_cnt > n0), 32'd1);
		expect_value("resets", 32'(resets), 32'(exp_lines));

		run_command(smpc_pkg::CMD_RESENAB);
		exp_resd = 1'b0;
		run_intback();
		run_command(smpc_pkg::CMD_RESDISA);
		exp_resd = 1'b1;
		run_intback();

		set_time = '{year: 16'h1999, day: 4'd5, month: 4'd12, days: 8'h31,
			hour: 8'h23, min: 8'h59, sec: 8'h58};
		settime_check(set_time);	// Crosses the year
		set_time = '{year: 16'h2023, day: 4'd2, month: 4'd2, days: 8'h28,
			hour: 8'h23, min: 8'h59, sec: 8'h58};
		settime_check(set_time);	// Crosses the end of February

		mres_n <= 1'b0;
		repeat (3) @(posedge CLK);
		mres_n <= 1'b1;
		bus_read(smpc_pkg::ADDR_SR, sr_before);
		expect_value("sr after mres_n", 32'(sr_before), 32'h00);
		write_iregs({8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01});
		n0 = mirq_low_cnt;
		run_command(smpc_pkg::CMD_INTBACK);
		expect_value("mirq_n low without status request", 32'(mirq_low_cnt > n0), 32'd0);
		bus_read(smpc_pkg::ADDR_SR, v);
		expect_value("sr", 32'(v), 32'(sr_before));

		$display("TEST OK");
		$finish;
	end

endmodule

/* tb/smpc_asserts.sv */
`timescale 1ns/1ps

module smpc_asserts (
	input logic                CLK,
	input logic                RST_N,
	input logic                cmd_done,
	input logic                in_end,
	input logic                mirq_n,
	input smpc_pkg::oreg_wr_t  oreg_wr
);

	done_leaves_end: assert property (@(posedge CLK) disable iff (!RST_N) cmd_done |=> !in_end)
		else $error("END state held after cmd_done");

	mirq_single: assert property (@(posedge CLK) disable iff (!RST_N) !mirq_n |=> mirq_n)
		else $error("mirq_n held low for more than one cycle");

	oreg_addr_step: assert property (@(posedge CLK) disable iff (!RST_N)
		oreg_wr.we && $past(oreg_wr.we) |-> oreg_wr.addr == $past(oreg_wr.addr) + 5'd1)
		else $error("OREG write stream skipped an index");

endmodule

bind smpc_cmd_seq smpc_asserts u_asserts (
	.CLK      (CLK),
	.RST_N    (RST_N),
	.cmd_done (cmd_done),
	.in_end   (state == ST_END),
	.mirq_n   (mirq_n),
	.oreg_wr  (oreg_wr)
);

/* tb/smpc_clkgen.sv */
`timescale 1ns/1ps

module smpc_clkgen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	initial begin
		RST_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		RST_N <= 1'b1;	// Release on a clock edge
	end

endmodule

/* src/smpc.sv */
`timescale 1ns/1ps

module smpc #(
	parameter logic [31:0] TICKS_PER_SEC = 32'd4000000
) (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    ce,
	input  logic                    mres_n,
	input  logic                    time_set_in,
	input  logic [3:0]              ac,
	input  logic [6:1]              a,
	input  logic [7:0]              di,
	output logic [7:0]              dout,
	input  logic                    cs_n,
	input  logic                    rw_n,
	output smpc_pkg::reset_lines_t  resets,
	output logic                    mirq_n
);

	logic                cmd_strobe;
	logic                cmd_done;
	logic [7:0]          comreg;
	logic [6:0][7:0]     ireg;
	logic [7:0]          sr;
	logic [7:0]          oreg_q;
	logic [4:0]          oreg_raddr;
	logic                time_set;
	smpc_pkg::oreg_wr_t  oreg_wr;
	smpc_pkg::rtc_time_t now;

	smpc_host_regs u_host_regs (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.a          (a),
		.di         (di),
		.cs_n       (cs_n),
		.rw_n       (rw_n),
		.dout       (dout),
		.sr         (sr),
		.oreg_q     (oreg_q),
		.oreg_raddr (oreg_raddr),
		.cmd_done   (cmd_done),
		.cmd_strobe (cmd_strobe),
		.comreg     (comreg),
		.ireg       (ireg)
	);

	smpc_cmd_seq u_cmd_seq (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.ce          (ce),
		.mres_n      (mres_n),
		.time_set_in (time_set_in),
		.ac          (ac),
		.cmd_strobe  (cmd_strobe),
		.comreg      (comreg),
		.ireg        (ireg),
		.now         (now),
		.cmd_done    (cmd_done),
		.time_set    (time_set),
		.oreg_wr     (oreg_wr),
		.sr          (sr),
		.resets      (resets),
		.mirq_n      (mirq_n)
	);

	smpc_rtc #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_rtc (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.ce       (ce),
		.time_set (time_set),
		.ireg     (ireg),
		.now      (now)
	);

	smpc_oreg_ram u_oreg_ram (
		.CLK   (CLK),
		.wr    (oreg_wr),
		.raddr (oreg_raddr),
		.q     (oreg_q)
	);

endmodule

/* src/smpc_cmd_seq.sv */
`timescale 1ns/1ps

module smpc_cmd_seq (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    ce,
	input  logic                    mres_n,
	input  logic                    time_set_in,
	input  logic [3:0]              ac,
	input  logic                    cmd_strobe,
	input  logic [7:0]              comreg,
	input  logic [6:0][7:0]         ireg,
	input  smpc_pkg::rtc_time_t     now,
	output logic                    cmd_done,
	output logic                    time_set,
	output smpc_pkg::oreg_wr_t      oreg_wr,
	output logic [7:0]              sr,
	output smpc_pkg::reset_lines_t  resets,
	output logic                    mirq_n
);

	typedef enum logic [2:0] {ST_IDLE, ST_WAIT, ST_COMMAND, ST_EXEC, ST_END} state_t;

	state_t      state;
	state_t      after_wait;
	logic [15:0] wait_cnt;
	logic [4:0]  oreg_cnt;
	logic        cmd_pend;
	logic        start;
	logic        ste;
	logic        resd;
	logic [7:0]  status_byte;

	assign start = mres_n && ce && state == ST_IDLE && cmd_pend;
	assign cmd_done = ce && state == ST_END;
	assign time_set = ce && state == ST_EXEC && comreg == smpc_pkg::CMD_SETTIME;

	// INTBACK status block, one byte per OREG index
	always_comb begin
		case (oreg_cnt)
			5'd0: status_byte = {ste, resd, 6'b000000};
			5'd1: status_byte = now.year[15:8];
			5'd2: status_byte = now.year[7:0];
			5'd3: status_byte = {now.day, now.month};
			5'd4: status_byte = now.days;
			5'd5: status_byte = now.hour;
			5'd6: status_byte = now.min;
			5'd7: status_byte = now.sec;
			5'd9: status_byte = {4'b0000, ac};
			5'd10: status_byte = {4'b0011, ~resets.mshnmi_n, 1'b0, ~resets.sysres_n,
				~resets.sndres_n};
			5'd11: status_byte = {1'b0, ~resets.cdres_n, 6'b000000};
			smpc_pkg::OREG_COMREG_SLOT: status_byte = comreg;
			default: status_byte = 8'h00;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) cmd_pend <= 1'b0;
		else if (cmd_strobe) cmd_pend <= 1'b1;
		else if (start) cmd_pend <= 1'b0;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ST_IDLE;
			after_wait <= ST_IDLE;
			wait_cnt <= '0;
			oreg_cnt <= '0;
			oreg_wr <= '0;
			sr <= '0;
			resets <= '0;	// Everything held in reset
			mirq_n <= 1'b1;
			ste <= 1'b0;
			resd <= 1'b1;
		end else if (!mres_n) begin
			resets <= '{mshres_n: 1'b1, mshnmi_n: 1'b1, sshres_n: 1'b0, sshnmi_n: 1'b1,
				sysres_n: 1'b1, sndres_n: 1'b0, cdres_n: 1'b1};
			sr <= '0;
			resd <= 1'b1;
			ste <= time_set_in;
			mirq_n <= 1'b1;
			oreg_wr.we <= 1'b0;
			state <= ST_IDLE;
		end else begin
			oreg_wr.we <= 1'b0;
			if (ce) begin
				mirq_n <= 1'b1;
				if (wait_cnt != 16'd0) wait_cnt <= wait_cnt - 16'd1;

				case (state)
					ST_IDLE: begin
						if (start) begin
							oreg_cnt <= '0;
							wait_cnt <= smpc_pkg::WAIT_CMD;
							after_wait <= ST_COMMAND;
							state <= ST_WAIT;
						end
					end

					ST_WAIT: if (wait_cnt == 16'd0) state <= after_wait;

					ST_COMMAND: begin
						after_wait <= ST_EXEC;
						state <= ST_WAIT;
						case (comreg)
							smpc_pkg::CMD_MSHON, smpc_pkg::CMD_SSHON, smpc_pkg::CMD_SSHOFF,
							smpc_pkg::CMD_SNDON, smpc_pkg::CMD_SNDOFF:
								wait_cnt <= smpc_pkg::WAIT_POWER;
							smpc_pkg::CMD_CDON, smpc_pkg::CMD_CDOFF:
								wait_cnt <= smpc_pkg::WAIT_CD;
							smpc_pkg::CMD_NMIREQ, smpc_pkg::CMD_RESENAB, smpc_pkg::CMD_RESDISA:
								wait_cnt <= smpc_pkg::WAIT_MISC;
							smpc_pkg::CMD_SETTIME: wait_cnt <= smpc_pkg::WAIT_SETTIME;
							smpc_pkg::CMD_INTBACK: begin
								if (ireg[2] == 8'hF0 && ireg[0][0])	// Status request only
									wait_cnt <= smpc_pkg::WAIT_INTBACK;
								else
									state <= ST_END;
							end
							default: state <= ST_EXEC;
						endcase
					end

					ST_EXEC: begin
						oreg_wr <= '{we: 1'b1, addr: smpc_pkg::OREG_COMREG_SLOT, data: comreg};
						state <= ST_END;
						case (comreg)
							smpc_pkg::CMD_MSHON: begin
								resets.mshres_n <= 1'b1;
								resets.mshnmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SSHON: begin
								resets.sshres_n <= 1'b1;
								resets.sshnmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SSHOFF: begin
								resets.sshres_n <= 1'b0;
								resets.sshnmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SNDON: resets.sndres_n <= 1'b1;
							smpc_pkg::CMD_SNDOFF: resets.sndres_n <= 1'b0;
							smpc_pkg::CMD_CDON: resets.cdres_n <= 1'b1;
							smpc_pkg::CMD_CDOFF: resets.cdres_n <= 1'b0;
							smpc_pkg::CMD_NMIREQ: resets.mshnmi_n <= 1'b0;
							smpc_pkg::CMD_RESENAB: resd <= 1'b0;
							smpc_pkg::CMD_RESDISA: resd <= 1'b1;
							smpc_pkg::CMD_SETTIME: ste <= 1'b1;
							smpc_pkg::CMD_INTBACK: begin
								oreg_wr <= '{we: 1'b1, addr: oreg_cnt, data: status_byte};
								oreg_cnt <= oreg_cnt + 5'd1;
								if (oreg_cnt == smpc_pkg::OREG_COMREG_SLOT) begin
									sr <= 8'h4F;
									mirq_n <= 1'b0;	// Tell the master the block is ready
								end else begin
									state <= ST_EXEC;
								end
							end
							default: ;
						endcase
					end

					ST_END: begin
						if (comreg == smpc_pkg::CMD_NMIREQ) resets.mshnmi_n <= 1'b1;
						state <= ST_IDLE;
					end

					default: state <= ST_IDLE;
				endcase
			end
		end
	end

endmodule

/* src/smpc_host_regs.sv */
`timescale 1ns/1ps

module smpc_host_regs (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic [6:1]       a,
	input  logic [7:0]       di,
	input  logic             cs_n,
	input  logic             rw_n,
	output logic [7:0]       dout,
	input  logic [7:0]       sr,
	input  logic [7:0]       oreg_q,
	output logic [4:0]       oreg_raddr,
	input  logic             cmd_done,
	output logic             cmd_strobe,
	output logic [7:0]       comreg,
	output logic [6:0][7:0]  ireg
);

	smpc_pkg::host_wr_t wr;
	logic               rw_n_old;
	logic               cs_n_old;
	logic               wr_edge;
	logic               rd_edge;
	logic [6:0]         rd_addr;
	logic [6:0]         ireg_off;
	logic [5:0]         oreg_idx;
	logic               sf;

	assign wr = '{addr: {a, 1'b1}, data: di};
	assign rd_addr = {a, 1'b1};
	assign wr_edge = !rw_n && rw_n_old && !cs_n;
	assign rd_edge = !cs_n && cs_n_old && rw_n;
	assign ireg_off = wr.addr - smpc_pkg::ADDR_IREG0;	// IREGn sits at 01 + 2n
	assign oreg_idx = a - 6'h10;
	assign oreg_raddr = oreg_idx[4:0];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old <= 1'b1;
			cs_n_old <= 1'b1;
			cmd_strobe <= 1'b0;
			comreg <= '0;
			ireg <= '0;
			sf <= 1'b0;
			dout <= '0;
		end else begin
			rw_n_old <= rw_n;
			cs_n_old <= cs_n;
			cmd_strobe <= 1'b0;

			if (cmd_done) sf <= 1'b0;

			if (wr_edge) begin
				if (ireg_off < 7'd13) ireg[ireg_off[3:1]] <= wr.data;
				if (wr.addr == smpc_pkg::ADDR_COMREG) begin
					comreg <= wr.data;
					cmd_strobe <= 1'b1;
				end
				if (wr.addr == smpc_pkg::ADDR_SF && wr.data[0]) sf <= 1'b1;	// Host raises SF
			end

			if (rd_edge) begin
				if (rd_addr <= smpc_pkg::ADDR_OREG_LAST)
					dout <= oreg_q;
				else if (rd_addr == smpc_pkg::ADDR_SR)
					dout <= sr;
				else if (rd_addr == smpc_pkg::ADDR_SF)
					dout <= {7'b0000000, sf};
				else
					dout <= 8'h00;
			end
		end
	end

endmodule

/* src/smpc_rtc.sv */
`timescale 1ns/1ps

module smpc_rtc #(
	parameter logic [31:0] TICKS_PER_SEC = 32'd4000000
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic                 time_set,
	input  logic [6:0][7:0]      ireg,
	output smpc_pkg::rtc_time_t  now
);

	logic [31:0] tick_cnt;
	logic        sec_tick;
	logic        min_carry;
	logic        hour_carry;
	logic        days_carry;
	logic        month_carry;
	logic        year_carry;
	logic        month_end;

	function automatic logic [7:0] bcd_inc(input logic [7:0] v);
		if (v[3:0] == 4'd9)
			bcd_inc = {v[7:4] + 4'd1, 4'd0};
		else
			bcd_inc = {v[7:4], v[3:0] + 4'd1};
	endfunction

	assign sec_tick = ce && tick_cnt == TICKS_PER_SEC - 32'd1;
	assign min_carry = sec_tick && now.sec == 8'h59;
	assign hour_carry = min_carry && now.min == 8'h59;
	assign days_carry = hour_carry && now.hour == 8'h23;
	assign month_carry = days_carry && month_end;
	assign year_carry = month_carry && now.month == 4'd12;

	assign month_end = (now.month == 4'd2 && now.days == 8'h28) ||
		((now.month == 4'd4 || now.month == 4'd6 || now.month == 4'd9 ||
		now.month == 4'd11) && now.days == 8'h30) || now.days == 8'h31;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tick_cnt <= '0;
			now <= '{year: 16'h2024, day: 4'd0, month: 4'd1, days: 8'h01,
				hour: 8'h00, min: 8'h00, sec: 8'h00};
		end else if (time_set) begin
			tick_cnt <= '0;	// Restart the second on load
			now <= '{year: {ireg[0], ireg[1]}, day: ireg[2][7:4], month: ireg[2][3:0],
				days: ireg[3], hour: ireg[4], min: ireg[5], sec: ireg[6]};
		end else if (ce) begin
			tick_cnt <= sec_tick ? 32'd0 : tick_cnt + 32'd1;
			if (sec_tick) now.sec <= (now.sec == 8'h59) ? 8'h00 : bcd_inc(now.sec);
			if (min_carry) now.min <= (now.min == 8'h59) ? 8'h00 : bcd_inc(now.min);
			if (hour_carry) now.hour <= (now.hour == 8'h23) ? 8'h00 : bcd_inc(now.hour);
			if (days_carry) now.days <= month_end ? 8'h01 : bcd_inc(now.days);
			if (month_carry) now.month <= (now.month == 4'd12) ? 4'd1 : now.month + 4'd1;
			if (year_carry) begin
				now.year[7:0] <= (now.year[7:0] == 8'h99) ? 8'h00 : bcd_inc(now.year[7:0]);
				if (now.year[7:0] == 8'h99) now.year[15:8] <= bcd_inc(now.year[15:8]);	// Century
			end
		end
	end

endmodule

/* src/smpc_oreg_ram.sv */
`timescale 1ns/1ps

module smpc_oreg_ram (
	input  logic                CLK,
	input  smpc_pkg::oreg_wr_t  wr,
	input  logic [4:0]          raddr,
	output logic [7:0]          q
);

	logic [7:0] mem [32];

	always_ff @(posedge CLK) begin
		if (wr.we) mem[wr.addr] <= wr.data;
	end

	assign q = mem[raddr];	// Host side reads without a clock

endmodule

/* src/smpc_pkg.sv */
package smpc_pkg;

	localparam logic [7:0] CMD_MSHON   = 8'h00;
	localparam logic [7:0] CMD_SSHON   = 8'h02;
	localparam logic [7:0] CMD_SSHOFF  = 8'h03;
	localparam logic [7:0] CMD_SNDON   = 8'h06;
	localparam logic [7:0] CMD_SNDOFF  = 8'h07;
	localparam logic [7:0] CMD_CDON    = 8'h08;
	localparam logic [7:0] CMD_CDOFF   = 8'h09;
	localparam logic [7:0] CMD_INTBACK = 8'h10;
	localparam logic [7:0] CMD_SETTIME = 8'h16;
	localparam logic [7:0] CMD_NMIREQ  = 8'h18;
	localparam logic [7:0] CMD_RESENAB = 8'h19;
	localparam logic [7:0] CMD_RESDISA = 8'h1A;

	localparam logic [6:0] ADDR_IREG0     = 7'h01;
	localparam logic [6:0] ADDR_COMREG    = 7'h1F;
	localparam logic [6:0] ADDR_OREG_LAST = 7'h5F;
	localparam logic [6:0] ADDR_SR        = 7'h61;
	localparam logic [6:0] ADDR_SF        = 7'h63;

	// Command delays, counted in CE cycles
	localparam logic [15:0] WAIT_CMD     = 16'd90;
	localparam logic [15:0] WAIT_POWER   = 16'd120;
	localparam logic [15:0] WAIT_CD      = 16'd159;
	localparam logic [15:0] WAIT_MISC    = 16'd127;
	localparam logic [15:0] WAIT_SETTIME = 16'd279;
	localparam logic [15:0] WAIT_INTBACK = 16'd800;

	localparam logic [4:0] OREG_COMREG_SLOT = 5'd31;

	typedef struct packed {
		logic [6:0] addr;
		logic [7:0] data;
	} host_wr_t;

	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sysres_n;
		logic sndres_n;
		logic cdres_n;
	} reset_lines_t;

	typedef struct packed {
		logic       we;
		logic [4:0] addr;
		logic [7:0] data;
	} oreg_wr_t;

	typedef struct packed {
		logic [15:0] year;
		logic [3:0]  day;	// Day of week, binary
		logic [3:0]  month;
		logic [7:0]  days;
		logic [7:0]  hour;
		logic [7:0]  min;
		logic [7:0]  sec;
	} rtc_time_t;

endpackage
